/* common/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // Operation class as seen by execute
    typedef enum logic [3:0] {
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        OP_LOAD,
        OP_STORE,
        OP_ALU_IMM,
        OP_ALU_REG,
        OP_ILLEGAL
    } op_t;

    // Base opcodes, inst[6:0]
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // funct7 values allowed in RV32I
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA, SRAI

endpackage

`default_nettype wire

/* common/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    localparam int REG_COUNT   = 32;
    localparam int FWD_SOURCES = 3;

    // Forwarding source index, lower index wins
    localparam int FWD_EX  = 0;
    localparam int FWD_MEM = 1;
    localparam int FWD_WB  = 2;

endpackage

`default_nettype wire

/* decode/op_classifier.sv */
`default_nettype none

module op_classifier (
    input  isa_pkg::word_t inst,
    output isa_pkg::op_t   op,
    output logic           illegal,
    output logic           reg_write
);

    import isa_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        op = OP_ILLEGAL;
        unique case (inst[6:0])
            OPC_LUI:    op = OP_LUI;
            OPC_AUIPC:  op = OP_AUIPC;
            OPC_JAL:    op = OP_JAL;
            OPC_JALR:   if (funct3 == 3'd0) op = OP_JALR;
            OPC_BRANCH: if (funct3 != 3'd2 && funct3 != 3'd3) op = OP_BRANCH;
            OPC_LOAD:   if (funct3 != 3'd3 && funct3 < 3'd6) op = OP_LOAD;
            OPC_STORE:  if (funct3 < 3'd3) op = OP_STORE;
            OPC_OP_IMM: begin
                if (funct3 == 3'd1) begin // SLLI
                    if (funct7 == F7_BASE) op = OP_ALU_IMM;
                end else if (funct3 == 3'd5) begin // SRLI / SRAI
                    if (funct7 == F7_BASE || funct7 == F7_ALT) op = OP_ALU_IMM;
                end else begin
                    op = OP_ALU_IMM;
                end
            end
            OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    op = OP_ALU_REG;
                end else if (funct7 == F7_ALT && (funct3 == 3'd0 || funct3 == 3'd5)) begin
                    op = OP_ALU_REG;
                end
            end
            default: op = OP_ILLEGAL;
        endcase
    end

    assign illegal = (op == OP_ILLEGAL);

    // Branches and stores have no rd
    always_comb begin
        unique case (op)
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
            OP_LOAD, OP_ALU_IMM, OP_ALU_REG: reg_write = 1'b1;
            default:                         reg_write = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* decode/immed_gen.sv */
`default_nettype none

module immed_gen (
    input  isa_pkg::word_t inst,
    output isa_pkg::word_t immed
);

    import isa_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (inst[6:0])
            OPC_JALR,
            OPC_LOAD,
            OPC_OP_IMM: immed = imm_i;
            OPC_STORE:  immed = imm_s;
            OPC_BRANCH: immed = imm_b;
            OPC_LUI,
            OPC_AUIPC:  immed = imm_u;
            OPC_JAL:    immed = imm_j;
            default:    immed = '0; // R type and unknown
        endcase
    end

endmodule

`default_nettype wire

/* decode/operand_forward.sv */
`default_nettype none

module operand_forward (
    input  isa_pkg::reg_addr_t addr,
    input  isa_pkg::word_t     rf_value,
    input  logic               ex_we,
    input  isa_pkg::reg_addr_t ex_rd,
    input  isa_pkg::word_t     ex_data,
    input  logic               mem_we,
    input  isa_pkg::reg_addr_t mem_rd,
    input  isa_pkg::word_t     mem_data,
    input  logic               wb_we,
    input  isa_pkg::reg_addr_t wb_rd,
    input  isa_pkg::word_t     wb_data,
    output isa_pkg::word_t     value
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic [FWD_SOURCES-1:0] hit;
    word_t                  src_data [FWD_SOURCES];

    assign hit[FWD_EX]  = ex_we  && (ex_rd  != '0) && (ex_rd  == addr);
    assign hit[FWD_MEM] = mem_we && (mem_rd != '0) && (mem_rd == addr);
    assign hit[FWD_WB]  = wb_we  && (wb_rd  != '0) && (wb_rd  == addr);

    assign src_data[FWD_EX]  = ex_data;
    assign src_data[FWD_MEM] = mem_data;
    assign src_data[FWD_WB]  = wb_data;

    // Walk from lowest priority up so the youngest producer wins
    always_comb begin
        value = rf_value;
        for (int i = FWD_SOURCES - 1; i >= 0; i--) begin
            if (hit[i]) value = src_data[i];
        end
    end

    // x0 falls through to the register file, which must return zero
    always_comb begin
        if (addr == '0 && hit == '0) begin
            a_x0_reads_zero: assert #0 (value == '0);
        end
    end

endmodule

`default_nettype wire

/* decode/decoder.sv */
`default_nettype none

module decoder (
    input  isa_pkg::word_t     inst,
    input  isa_pkg::word_t     pc,
    input  logic               valid,
    input  isa_pkg::word_t     rf_rd1_value,
    input  isa_pkg::word_t     rf_rd2_value,
    input  logic               fwd_ex_we,
    input  isa_pkg::reg_addr_t fwd_ex_rd,
    input  isa_pkg::word_t     fwd_ex_data,
    input  logic               fwd_mem_we,
    input  isa_pkg::reg_addr_t fwd_mem_rd,
    input  isa_pkg::word_t     fwd_mem_data,
    input  logic               fwd_wb_we,
    input  isa_pkg::reg_addr_t fwd_wb_rd,
    input  isa_pkg::word_t     fwd_wb_data,
    output isa_pkg::reg_addr_t rs1,
    output isa_pkg::reg_addr_t rs2,
    output isa_pkg::reg_addr_t rd,
    output isa_pkg::op_t       op,
    output logic               illegal,
    output logic               reg_write,
    output isa_pkg::word_t     rs1_value,
    output isa_pkg::word_t     rs2_value,
    output isa_pkg::word_t     immed,
    output logic               dec_valid,
    output isa_pkg::word_t     dec_pc
);

    import pipe_pkg::*;

    logic cls_reg_write;

    if (FWD_SOURCES != 3) begin : g_fwd_check
        $error("decoder connects exactly three forwarding sources");
    end

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    op_classifier op_classifier_i (
        .inst      (inst),
        .op        (op),
        .illegal   (illegal),
        .reg_write (cls_reg_write)
    );

    immed_gen immed_gen_i (
        .inst  (inst),
        .immed (immed)
    );

    operand_forward fwd_rs1_i (
        .addr (rs1), .rf_value (rf_rd1_value),
        .ex_we (fwd_ex_we), .ex_rd (fwd_ex_rd), .ex_data (fwd_ex_data),
        .mem_we (fwd_mem_we), .mem_rd (fwd_mem_rd), .mem_data (fwd_mem_data),
        .wb_we (fwd_wb_we), .wb_rd (fwd_wb_rd), .wb_data (fwd_wb_data),
        .value (rs1_value)
    );

    operand_forward fwd_rs2_i (
        .addr (rs2), .rf_value (rf_rd2_value),
        .ex_we (fwd_ex_we), .ex_rd (fwd_ex_rd), .ex_data (fwd_ex_data),
        .mem_we (fwd_mem_we), .mem_rd (fwd_mem_rd), .mem_data (fwd_mem_data),
        .wb_we (fwd_wb_we), .wb_rd (fwd_wb_rd), .wb_data (fwd_wb_data),
        .value (rs2_value)
    );

    assign reg_write = cls_reg_write & valid; // Bubbles never write back
    assign dec_valid = valid;
    assign dec_pc    = pc;

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::reg_addr_t rs1,
    input  isa_pkg::reg_addr_t rs2,
    output isa_pkg::word_t     rd1_value,
    output isa_pkg::word_t     rd2_value,
    input  logic               we,
    input  isa_pkg::reg_addr_t wr_addr,
    input  isa_pkg::word_t     wr_data
);

    import isa_pkg::*;
    import pipe_pkg::*;

    word_t regs [REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Old value on a same-cycle write, forwarding covers it
    assign rd1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2_value = (rs2 == '0) ? '0 : regs[rs2];

    a_x0_stable: assert property (@(posedge clk) disable iff (!rst_n)
        $stable(regs[0]) && regs[0] == '0);

endmodule

`default_nettype wire

/* rtl/id_ex_reg.sv */
`default_nettype none

module id_ex_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,
    input  logic               valid,
    output logic               ex_valid,
    input  isa_pkg::op_t       op,
    output isa_pkg::op_t       ex_op,
    input  logic               illegal,
    output logic               ex_illegal,
    input  logic               reg_write,
    output logic               ex_reg_write,
    input  isa_pkg::reg_addr_t rd,
    output isa_pkg::reg_addr_t ex_rd,
    input  isa_pkg::reg_addr_t rs1,
    output isa_pkg::reg_addr_t ex_rs1,
    input  isa_pkg::reg_addr_t rs2,
    output isa_pkg::reg_addr_t ex_rs2,
    input  isa_pkg::word_t     rs1_value,
    output isa_pkg::word_t     ex_rs1_value,
    input  isa_pkg::word_t     rs2_value,
    output isa_pkg::word_t     ex_rs2_value,
    input  isa_pkg::word_t     immed,
    output isa_pkg::word_t     ex_immed,
    input  isa_pkg::word_t     pc,
    output isa_pkg::word_t     ex_pc
);

    import isa_pkg::*;

    // Flush wins over stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
        end else if (flush) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
        end else if (!stall) begin
            ex_valid     <= valid;
            ex_reg_write <= reg_write;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_op        <= op_t'('0);
            ex_illegal   <= 1'b0;
            ex_rd        <= '0;
            ex_rs1       <= '0;
            ex_rs2       <= '0;
            ex_rs1_value <= '0;
            ex_rs2_value <= '0;
            ex_immed     <= '0;
            ex_pc        <= '0;
        end else if (!stall) begin
            ex_op        <= op;
            ex_illegal   <= illegal;
            ex_rd        <= rd;
            ex_rs1       <= rs1;
            ex_rs2       <= rs2;
            ex_rs1_value <= rs1_value;
            ex_rs2_value <= rs2_value;
            ex_immed     <= immed;
            ex_pc        <= pc;
        end
    end

    a_write_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ex_reg_write |-> ex_valid);

endmodule

`default_nettype wire

/* rtl/decode_stage_top.sv */
`default_nettype none

module decode_stage_top (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::word_t     if_inst,
    input  isa_pkg::word_t     if_pc,
    input  logic               if_valid,
    input  logic               stall,
    input  logic               flush,
    input  logic               fwd_ex_we,
    input  isa_pkg::reg_addr_t fwd_ex_rd,
    input  isa_pkg::word_t     fwd_ex_data,
    input  logic               fwd_mem_we,
    input  isa_pkg::reg_addr_t fwd_mem_rd,
    input  isa_pkg::word_t     fwd_mem_data,
    input  logic               fwd_wb_we,
    input  isa_pkg::reg_addr_t fwd_wb_rd,
    input  isa_pkg::word_t     fwd_wb_data,
    output logic               ex_valid,
    output isa_pkg::op_t       ex_op,
    output logic               ex_illegal,
    output logic               ex_reg_write,
    output isa_pkg::reg_addr_t ex_rd,
    output isa_pkg::reg_addr_t ex_rs1,
    output isa_pkg::reg_addr_t ex_rs2,
    output isa_pkg::word_t     ex_rs1_value,
    output isa_pkg::word_t     ex_rs2_value,
    output isa_pkg::word_t     ex_immed,
    output isa_pkg::word_t     ex_pc
);

    import isa_pkg::*;
    import pipe_pkg::*;

    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    reg_addr_t dec_rd;
    word_t     rf_rd1_value;
    word_t     rf_rd2_value;
    op_t       dec_op;
    logic      dec_illegal;
    logic      dec_reg_write;
    word_t     dec_rs1_value;
    word_t     dec_rs2_value;
    word_t     dec_immed;
    logic      dec_valid;
    word_t     dec_pc;

    if (FWD_SOURCES != 3) begin : g_fwd_check
        $error("top level exposes exactly three forwarding ports");
    end

    reg_file reg_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .rd1_value (rf_rd1_value),
        .rd2_value (rf_rd2_value),
        .we        (fwd_wb_we), // Writeback doubles as the write port
        .wr_addr   (fwd_wb_rd),
        .wr_data   (fwd_wb_data)
    );

    decoder decoder_i (
        .inst         (if_inst),
        .pc           (if_pc),
        .valid        (if_valid),
        .rf_rd1_value (rf_rd1_value),
        .rf_rd2_value (rf_rd2_value),
        .fwd_ex_we    (fwd_ex_we),
        .fwd_ex_rd    (fwd_ex_rd),
        .fwd_ex_data  (fwd_ex_data),
        .fwd_mem_we   (fwd_mem_we),
        .fwd_mem_rd   (fwd_mem_rd),
        .fwd_mem_data (fwd_mem_data),
        .fwd_wb_we    (fwd_wb_we),
        .fwd_wb_rd    (fwd_wb_rd),
        .fwd_wb_data  (fwd_wb_data),
        .rs1          (dec_rs1),
        .rs2          (dec_rs2),
        .rd           (dec_rd),
        .op           (dec_op),
        .illegal      (dec_illegal),
        .reg_write    (dec_reg_write),
        .rs1_value    (dec_rs1_value),
        .rs2_value    (dec_rs2_value),
        .immed        (dec_immed),
        .dec_valid    (dec_valid),
        .dec_pc       (dec_pc)
    );

    id_ex_reg id_ex_reg_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .flush        (flush),
        .valid        (dec_valid),
        .ex_valid     (ex_valid),
        .op           (dec_op),
        .ex_op        (ex_op),
        .illegal      (dec_illegal),
        .ex_illegal   (ex_illegal),
        .reg_write    (dec_reg_write),
        .ex_reg_write (ex_reg_write),
        .rd           (dec_rd),
        .ex_rd        (ex_rd),
        .rs1          (dec_rs1),
        .ex_rs1       (ex_rs1),
        .rs2          (dec_rs2),
        .ex_rs2       (ex_rs2),
        .rs1_value    (dec_rs1_value),
        .ex_rs1_value (ex_rs1_value),
        .rs2_value    (dec_rs2_value),
        .ex_rs2_value (ex_rs2_value),
        .immed        (dec_immed),
        .ex_immed     (ex_immed),
        .pc           (dec_pc),
        .ex_pc        (ex_pc)
    );

endmodule

`default_nettype wire

/* tb/tb_decode_stage.sv */
`default_nettype none

module tb_decode_stage;

    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 5;
    localparam int RANDOM_CYCLES = 400;
    localparam int CTRL_CYCLES   = 300;
    localparam int DRAIN_CYCLES  = 3;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + RANDOM_CYCLES + CTRL_CYCLES + DRAIN_CYCLES + 1;

    typedef struct packed {
        logic      valid;
        op_t       op;
        logic      illegal;
        logic      reg_write;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     rs1_value;
        word_t     rs2_value;
        word_t     immed;
        word_t     pc;
    } exp_t;

    logic      clk = 1'b0;
    logic      rst_n;
    word_t     if_inst;
    word_t     if_pc;
    logic      if_valid;
    logic      stall;
    logic      flush;
    logic      fwd_ex_we;
    reg_addr_t fwd_ex_rd;
    word_t     fwd_ex_data;
    logic      fwd_mem_we;
    reg_addr_t fwd_mem_rd;
    word_t     fwd_mem_data;
    logic      fwd_wb_we;
    reg_addr_t fwd_wb_rd;
    word_t     fwd_wb_data;
    logic      ex_valid;
    op_t       ex_op;
    logic      ex_illegal;
    logic      ex_reg_write;
    reg_addr_t ex_rd;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    word_t     ex_rs1_value;
    word_t     ex_rs2_value;
    word_t     ex_immed;
    word_t     ex_pc;

    logic [31:0] lcg_state = 32'hec05_643d;
    word_t       shadow_regs [REG_COUNT];
    exp_t        model;                      // Expected id/ex contents
    exp_t        exp_q [$];
    string       name_q [$];

    decode_stage_top dut_i (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic opcode_t opcode_for(input int kind);
        case (kind)
            0:       return OPC_LUI;
            1:       return OPC_AUIPC;
            2:       return OPC_JAL;
            3:       return OPC_JALR;
            4:       return OPC_BRANCH;
            5:       return OPC_LOAD;
            6:       return OPC_STORE;
            7:       return OPC_OP_IMM;
            default: return OPC_OP;
        endcase
    endfunction

    // Execute first, then memory, then writeback, else the register file
    function automatic word_t ref_operand(input reg_addr_t addr);
        if (fwd_ex_we && fwd_ex_rd != 5'd0 && fwd_ex_rd == addr) return fwd_ex_data;
        if (fwd_mem_we && fwd_mem_rd != 5'd0 && fwd_mem_rd == addr) return fwd_mem_data;
        if (fwd_wb_we && fwd_wb_rd != 5'd0 && fwd_wb_rd == addr) return fwd_wb_data;
        return shadow_regs[addr];
    endfunction

    function automatic exp_t ref_decode(input word_t inst, input word_t pc, input logic valid);
        exp_t       e;
        op_t        cls;
        logic       legal;
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = inst[14:12];
        f7 = inst[31:25];
        e = '0;
        cls = OP_ILLEGAL;
        legal = 1'b1;
        case (inst[6:0])
            OPC_LUI, OPC_AUIPC: begin
                cls = (inst[6:0] == OPC_LUI) ? OP_LUI : OP_AUIPC;
                e.immed = {inst[31:12], 12'h000};
            end
            OPC_JAL: begin
                cls = OP_JAL;
                e.immed = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                cls = OP_JALR;
                legal = (f3 == 3'd0);
                e.immed = {{21{inst[31]}}, inst[30:20]};
            end
            OPC_BRANCH: begin
                cls = OP_BRANCH;
                legal = !(f3 inside {3'd2, 3'd3});
                e.immed = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OPC_LOAD: begin
                cls = OP_LOAD;
                legal = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
                e.immed = {{21{inst[31]}}, inst[30:20]};
            end
            OPC_STORE: begin
                cls = OP_STORE;
                legal = f3 inside {3'd0, 3'd1, 3'd2};
                e.immed = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            end
            OPC_OP_IMM: begin
                cls = OP_ALU_IMM;
                if (f3 == 3'd1) legal = (f7 == 7'h00);
                else if (f3 == 3'd5) legal = f7 inside {7'h00, 7'h20};
                e.immed = {{21{inst[31]}}, inst[30:20]};
            end
            OPC_OP: begin
                cls = OP_ALU_REG;
                legal = (f7 == 7'h00) || (f7 == 7'h20 && f3 inside {3'd0, 3'd5});
            end
            default: legal = 1'b0;
        endcase
        e.op        = legal ? cls : OP_ILLEGAL;
        e.illegal   = !legal;
        e.reg_write = valid && legal && cls != OP_BRANCH && cls != OP_STORE;
        e.valid     = valid;
        e.pc        = pc;
        e.rd        = inst[11:7];
        e.rs1       = inst[19:15];
        e.rs2       = inst[24:20];
        e.rs1_value = ref_operand(inst[19:15]);
        e.rs2_value = ref_operand(inst[24:20]);
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "Stopping on mismatch in %s", name);
        end
    endtask

    task automatic check_outputs(input string name, input exp_t want);
        check_value({name, ".ex_valid"}, 32'(want.valid), 32'(ex_valid));
        check_value({name, ".ex_op"}, 32'(want.op), 32'(ex_op));
        check_value({name, ".ex_illegal"}, 32'(want.illegal), 32'(ex_illegal));
        check_value({name, ".ex_reg_write"}, 32'(want.reg_write), 32'(ex_reg_write));
        check_value({name, ".ex_rd"}, 32'(want.rd), 32'(ex_rd));
        check_value({name, ".ex_rs1"}, 32'(want.rs1), 32'(ex_rs1));
        check_value({name, ".ex_rs2"}, 32'(want.rs2), 32'(ex_rs2));
        check_value({name, ".ex_rs1_value"}, want.rs1_value, ex_rs1_value);
        check_value({name, ".ex_rs2_value"}, want.rs2_value, ex_rs2_value);
        check_value({name, ".ex_immed"}, want.immed, ex_immed);
        check_value({name, ".ex_pc"}, want.pc, ex_pc);
    endtask

    // Source rd aims at rs1, rs2, a random register or x0
    function automatic reg_addr_t pick_fwd_rd(input word_t inst, input logic [1:0] sel);
        logic [31:0] r;
        r = next_random();
        case (sel)
            2'd0:    return inst[19:15];
            2'd1:    return inst[24:20];
            2'd2:    return r[4:0];
            default: return 5'd0;
        endcase
    endfunction

    task automatic drive_random_cycle(input string phase, input logic use_ctrl);
        logic [31:0] r;
        int          kind;
        exp_t        dec;
        r = next_random();
        if_inst = next_random();
        kind = int'(r[7:0]) % 11;
        if (kind < 9) if_inst[6:0] = opcode_for(kind);       // Kinds 9 and 10 keep a raw opcode
        if ((kind == 7 || kind == 8) && r[9:8] != 2'b00) if_inst[31:25] = r[10] ? 7'h20 : 7'h00;
        if_pc        = next_random() & 32'hffff_fffc;
        if_valid     = (r[17:15] != 3'b000);
        fwd_ex_we    = r[11];
        fwd_ex_rd    = pick_fwd_rd(if_inst, r[13:12]);
        fwd_ex_data  = next_random();
        fwd_mem_we   = r[14];
        fwd_mem_rd   = pick_fwd_rd(if_inst, r[25:24]);
        fwd_mem_data = next_random();
        fwd_wb_we    = r[26];
        fwd_wb_rd    = pick_fwd_rd(if_inst, r[28:27]);
        fwd_wb_data  = next_random();
        stall        = use_ctrl && (r[20:18] < 3'd3);
        flush        = use_ctrl && (r[23:21] == 3'd0);
        dec = ref_decode(if_inst, if_pc, if_valid);
        if (!stall) model = dec;
        if (flush) begin
            model.valid     = 1'b0;
            model.reg_write = 1'b0;
        end
        exp_q.push_back(model);
        name_q.push_back(phase);
        if (fwd_wb_we && fwd_wb_rd != 5'd0) begin
            shadow_regs[fwd_wb_rd] = fwd_wb_data; // Lands at the edge
        end
    endtask

    initial begin : compare_proc
        exp_t  want;
        string name;
        forever begin
            @(posedge clk);
            #10;
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                name = name_q.pop_front();
                check_outputs(name, want);
            end
        end
    end

    initial begin : watchdog
        #(TOTAL_CYCLES * 2 * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("Regression failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        rst_n        = 1'b0;
        if_inst      = 32'h0000_0013;
        if_pc        = '0;
        if_valid     = 1'b0;
        stall        = 1'b0;
        flush        = 1'b0;
        fwd_ex_we    = 1'b0;
        fwd_ex_rd    = '0;
        fwd_ex_data  = '0;
        fwd_mem_we   = 1'b0;
        fwd_mem_rd   = '0;
        fwd_mem_data = '0;
        fwd_wb_we    = 1'b0;
        fwd_wb_rd    = '0;
        fwd_wb_data  = '0;
        model        = '0;
        for (int i = 0; i < REG_COUNT; i++) shadow_regs[i] = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        check_value("reset.ex_valid", 32'd0, 32'(ex_valid));
        check_value("reset.ex_reg_write", 32'd0, 32'(ex_reg_write));
        check_value("reset.ex_immed", 32'd0, ex_immed);
        check_value("reset.ex_pc", 32'd0, ex_pc);
        repeat (RANDOM_CYCLES) begin
            @(negedge clk);
            drive_random_cycle("random_decode", 1'b0);
        end
        repeat (CTRL_CYCLES) begin
            @(negedge clk);
            drive_random_cycle("stall_flush", 1'b1);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("Some expected results were never compared");
            $display("Regression failed");
            $fatal(1, "Compare queue not empty");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
common/isa_pkg.sv
common/pipe_pkg.sv
decode/op_classifier.sv
decode/immed_gen.sv
decode/operand_forward.sv
decode/decoder.sv
rtl/reg_file.sv
rtl/id_ex_reg.sv
rtl/decode_stage_top.sv
tb/tb_decode_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module tb_decode_stage -Mdir "$BUILD_DIR" -o tb_decode_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_decode_stage" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if grep -q "Regression failed" "$LOG_FILE"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation finished cleanly"
exit 0
